// File: compile.f
+incdir+common
common/pixel_pkg.sv
common/chunk_pkg.sv
common/axis_if.sv
capture/camera_capture.sv
capture/pixel_stacker.sv
hw/chunk_fifo.sv
hw/pixel_unstacker.sv
hw/camera_frame_path.sv
tests/tb_camera_frame_path.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_camera_frame_path
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_PATTERN ?= TEST RESULT: FAIL
PASS_PATTERN ?= TEST RESULT: PASS
VFLAGS ?= --timing

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_PATTERN)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_camera_frame_path.sv
`timescale 1ns/1ps

module tb_camera_frame_path
  import pixel_pkg::*;
();

  // small frame of one full chunk plus a partial of 14
  localparam int FRAME_W = 10;
  localparam int FRAME_H = 3;
  localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
  localparam int TIMEOUT_CYCLES = 3000;

  logic clk_camera;
  logic recent_reset;
  pixel_t camera_d;
  logic cam_pclk;
  logic cam_hsync;
  logic cam_vsync;
  logic pix_tready;
  logic pix_tvalid;
  pixel_t pix_tdata;
  logic pix_tlast;
  logic overflow;

  // 0 holds the sink stalled, 1 keeps it ready, 2 randomizes it
  int tready_mode;
  // expected stream in send order
  pixel_t exp_pix_q[$];
  logic exp_last_q[$];

  camera_frame_path #(
    .FRAME_W(FRAME_W),
    .FRAME_H(FRAME_H)
  ) i_camera_frame_path (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .camera_d_i  (camera_d),
    .cam_pclk_i  (cam_pclk),
    .cam_hsync_i (cam_hsync),
    .cam_vsync_i (cam_vsync),
    .pix_tready_i(pix_tready),
    .pix_tvalid_o(pix_tvalid),
    .pix_tdata_o (pix_tdata),
    .pix_tlast_o (pix_tlast),
    .overflow_o  (overflow)
  );

  initial begin
    clk_camera = 1'b0;
    forever #5 clk_camera = ~clk_camera;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_pixel(input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch pix_tdata_o: got 0x%02h expected 0x%02h", got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch pix_tlast_o: got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  // single-bit status outputs
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // every byte in send order with last at column W-1 of row H-1
  function automatic void build_expected(input pixel_t frame[FRAME_PIXELS]);
    for (int row = 0; row < FRAME_H; row++) begin
      for (int col = 0; col < FRAME_W; col++) begin
        exp_pix_q.push_back(frame[row * FRAME_W + col]);
        exp_last_q.push_back((row == FRAME_H - 1) && (col == FRAME_W - 1));
      end
    end
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_camera);
  endtask

  // camera bus model with pclk at a quarter of clk_camera
  task automatic send_frame(input bit expect_out);
    pixel_t frame [FRAME_PIXELS];
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      frame[i] = pixel_t'($urandom);
    end
    if (expect_out) begin
      build_expected(frame);
    end
    cam_vsync = 1'b1;
    idle_cycles(4);
    cam_vsync = 1'b0;
    idle_cycles(4);
    for (int row = 0; row < FRAME_H; row++) begin
      cam_hsync = 1'b1;
      idle_cycles(4);
      for (int col = 0; col < FRAME_W; col++) begin
        cam_pclk = 1'b0;
        idle_cycles(1);
        // new byte only while pclk is low
        camera_d = frame[row * FRAME_W + col];
        idle_cycles(1);
        cam_pclk = 1'b1;
        idle_cycles(2);
      end
      cam_pclk = 1'b0;
      idle_cycles(2);
      // hsync fall advances the row
      cam_hsync = 1'b0;
      idle_cycles(6);
    end
  endtask

  task automatic apply_reset();
    recent_reset = 1'b1;
    idle_cycles(4);
    recent_reset = 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int cycles = 0;
    while (exp_pix_q.size() != 0) begin
      @(negedge clk_camera);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("timed out in %s with %0d pixels never delivered",
                                    what, exp_pix_q.size()));
      end
    end
    // catch any stray pixel after the frame
    idle_cycles(20);
  endtask

  task automatic wait_overflow();
    int cycles = 0;
    while (overflow !== 1'b1) begin
      @(negedge clk_camera);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_with_failure("timed out waiting for overflow_o to rise with the output stalled");
      end
    end
  endtask

  // output sink ready changes on the falling edge
  initial begin
    pix_tready = 1'b0;
    forever begin
      @(negedge clk_camera);
      case (tready_mode)
        0:       pix_tready = 1'b0;
        1:       pix_tready = 1'b1;
        default: pix_tready = 1'($urandom % 2);
      endcase
    end
  end

  // compare every output transfer against the reference queue
  always @(posedge clk_camera) begin
    if (!recent_reset && pix_tvalid && pix_tready) begin
      if (exp_pix_q.size() == 0) begin
        stop_with_failure($sformatf("unexpected output pixel 0x%02h with nothing pending",
                                    pix_tdata));
      end else begin
        check_pixel(pix_tdata, exp_pix_q.pop_front());
        check_last(pix_tlast, exp_last_q.pop_front());
      end
    end
  end

  initial begin
    void'($urandom(50696));
    recent_reset = 1'b1;
    camera_d = '0;
    cam_pclk = 1'b0;
    cam_hsync = 1'b0;
    cam_vsync = 1'b0;
    tready_mode = 1;
    apply_reset();

    // one frame gives a full chunk then an early flush
    send_frame(1'b1);
    wait_drained("single frame");
    check_flag("overflow_o", overflow, 1'b0);

    // three frames under random back-pressure
    tready_mode = 2;
    repeat (3) send_frame(1'b1);
    wait_drained("random ready frames");
    check_flag("overflow_o", overflow, 1'b0);

    // back-to-back frames carry one last each
    tready_mode = 1;
    repeat (2) send_frame(1'b1);
    wait_drained("back-to-back frames");

    // ten chunks into a stalled sink overrun the buffering
    tready_mode = 0;
    idle_cycles(2);
    repeat (5) send_frame(1'b0);
    wait_overflow();

    // reset clears the sticky flag and the output
    apply_reset();
    check_flag("overflow_o", overflow, 1'b0);
    check_flag("pix_tvalid_o", pix_tvalid, 1'b0);
    tready_mode = 1;
    send_frame(1'b1);
    wait_drained("frame after reset");

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: hw/camera_frame_path.sv
`timescale 1ns/1ps
`include "camera_consts.svh"

module camera_frame_path
  import pixel_pkg::*;
  import chunk_pkg::*;
#(
  parameter int FRAME_W = `FRAME_W,
  parameter int FRAME_H = `FRAME_H
) (
  input  logic   clk_camera,
  input  logic   recent_reset,
  // camera pins
  input  pixel_t camera_d_i,
  input  logic   cam_pclk_i,
  input  logic   cam_hsync_i,
  input  logic   cam_vsync_i,
  // pixel stream out
  input  logic   pix_tready_i,
  output logic   pix_tvalid_o,
  output pixel_t pix_tdata_o,
  output logic   pix_tlast_o,
  output logic   overflow_o
);

  // capture -> stacker -> queue -> unstacker
  axis_if #(.payload_t(pixel_t)) pix_in ();
  axis_if #(.payload_t(chunk_t)) chunk_in ();
  axis_if #(.payload_t(chunk_t)) chunk_out ();
  axis_if #(.payload_t(pixel_t)) pix_out ();

  camera_capture #(
    .FRAME_W(FRAME_W),
    .FRAME_H(FRAME_H)
  ) i_camera_capture (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .camera_d_i  (camera_d_i),
    .cam_pclk_i  (cam_pclk_i),
    .cam_hsync_i (cam_hsync_i),
    .cam_vsync_i (cam_vsync_i),
    .pix_o       (pix_in)
  );

  pixel_stacker i_pixel_stacker (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .pix_i       (pix_in),
    .chunk_o     (chunk_in),
    .overflow_o  (overflow_o)
  );

  chunk_fifo #(
    .payload_t(chunk_t),
    .DEPTH    (`FIFO_DEPTH)
  ) i_chunk_fifo (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .wr_i        (chunk_in),
    .rd_o        (chunk_out)
  );

  pixel_unstacker i_pixel_unstacker (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .chunk_i     (chunk_out),
    .pix_o       (pix_out)
  );

  // flatten the output stream onto plain ports
  assign pix_out.tready = pix_tready_i;
  assign pix_tvalid_o = pix_out.tvalid;
  assign pix_tdata_o = pix_out.tdata;
  assign pix_tlast_o = pix_out.tlast;

endmodule

// File: hw/pixel_unstacker.sv
`timescale 1ns/1ps
`include "camera_consts.svh"

module pixel_unstacker
  import pixel_pkg::*;
  import chunk_pkg::*;
(
  input  logic   clk_camera,
  input  logic   recent_reset,
  axis_if.sink   chunk_i,
  axis_if.source pix_o
);

  localparam int LANE_W = $clog2(`CHUNK_PIXELS);

  // chunk being shifted out
  chunk_t held;
  logic held_last;
  logic busy;
  logic [LANE_W-1:0] lane_idx;
  logic last_lane;
  pixel_t lane_pix;

  assign lane_pix = held.data[lane_idx];
  // stop at the stored count, padding lanes never leave
  assign last_lane = (lane_count_t'(lane_idx) + lane_count_t'(1)) == held.count;
  assign pix_o.tvalid = busy;
  assign pix_o.tdata = lane_pix;
  assign pix_o.tlast = held_last && last_lane;
  // refill on the same cycle the final lane goes out
  assign chunk_i.tready = !busy || (pix_o.tready && last_lane);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      busy <= 1'b0;
      lane_idx <= '0;
    end else if (chunk_i.tvalid && chunk_i.tready) begin
      busy <= 1'b1;
      lane_idx <= '0;
    end else if (pix_o.tvalid && pix_o.tready) begin
      if (last_lane) begin
        busy <= 1'b0;
      end else begin
        lane_idx <= lane_idx + 1'b1;
      end
    end
  end

  // payload, only loaded on a chunk transfer
  always_ff @(posedge clk_camera) begin
    if (chunk_i.tvalid && chunk_i.tready) begin
      held <= chunk_i.tdata;
      held_last <= chunk_i.tlast;
    end
  end

endmodule

// File: hw/chunk_fifo.sv
`timescale 1ns/1ps
`include "camera_consts.svh"

module chunk_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `FIFO_DEPTH
) (
  input  logic   clk_camera,
  input  logic   recent_reset,
  axis_if.sink   wr_i,
  axis_if.source rd_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // storage, tlast kept beside each entry
  payload_t mem [DEPTH];
  logic last_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic do_wr;
  logic do_rd;

  assign wr_i.tready = (count != CNT_W'(DEPTH));
  // head entry shown directly, first word fall-through
  assign rd_o.tvalid = (count != '0);
  assign rd_o.tdata = mem[rd_ptr];
  assign rd_o.tlast = last_mem[rd_ptr];
  assign do_wr = wr_i.tvalid && wr_i.tready;
  assign do_rd = rd_o.tvalid && rd_o.tready;

  always_ff @(posedge clk_camera) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_i.tdata;
      last_mem[wr_ptr] <= wr_i.tlast;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // wrap by compare, DEPTH need not be a power of two
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: capture/pixel_stacker.sv
`timescale 1ns/1ps
`include "camera_consts.svh"

module pixel_stacker
  import chunk_pkg::*;
(
  input  logic   clk_camera,
  input  logic   recent_reset,
  axis_if.sink   pix_i,
  axis_if.source chunk_o,
  output logic   overflow_o
);

  localparam int LANE_W = $clog2(`CHUNK_PIXELS);

  // lanes collected so far
  chunk_data_t asm_data;
  // assembly plus the incoming pixel, upper lanes zeroed
  chunk_data_t fill_data;
  logic [LANE_W-1:0] lane_idx;
  logic pix_take;
  logic chunk_done;
  logic out_blocked;

  // never stalls the camera
  assign pix_i.tready = 1'b1;
  assign pix_take = pix_i.tvalid && pix_i.tready;
  // full chunk or early flush on frame end
  assign chunk_done = pix_take &&
                      ((lane_idx == LANE_W'(`CHUNK_PIXELS - 1)) || pix_i.tlast);
  // previous chunk still waiting on the queue
  assign out_blocked = chunk_o.tvalid && !chunk_o.tready;

  always_comb begin
    fill_data = '0;
    for (int i = 0; i < `CHUNK_PIXELS; i++) begin
      if (i < int'(lane_idx)) begin
        fill_data[i] = asm_data[i];
      end else if (i == int'(lane_idx)) begin
        fill_data[i] = pix_i.tdata;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (pix_take) begin
      asm_data[lane_idx] <= pix_i.tdata;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      lane_idx <= '0;
      chunk_o.tvalid <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      if (pix_take) begin
        lane_idx <= chunk_done ? '0 : lane_idx + 1'b1;
      end
      // new chunk dropped, flag sticks until reset
      if (chunk_done && out_blocked) begin
        overflow_o <= 1'b1;
      end else if (chunk_done) begin
        chunk_o.tvalid <= 1'b1;
      end else if (chunk_o.tvalid && chunk_o.tready) begin
        chunk_o.tvalid <= 1'b0;
      end
    end
  end

  // output register, loaded only when free or draining this cycle
  always_ff @(posedge clk_camera) begin
    if (chunk_done && !out_blocked) begin
      chunk_o.tdata.data <= fill_data;
      chunk_o.tdata.count <= lane_count_t'(lane_idx) + lane_count_t'(1);
      chunk_o.tlast <= pix_i.tlast;
    end
  end

endmodule

// File: capture/camera_capture.sv
`timescale 1ns/1ps
`include "camera_consts.svh"

module camera_capture
  import pixel_pkg::*;
#(
  parameter int FRAME_W = `FRAME_W,
  parameter int FRAME_H = `FRAME_H
) (
  input  logic   clk_camera,
  input  logic   recent_reset,
  input  pixel_t camera_d_i,
  input  logic   cam_pclk_i,
  input  logic   cam_hsync_i,
  input  logic   cam_vsync_i,
  axis_if.source pix_o
);

  localparam int LAST = `SYNC_STAGES - 1;

  // synchronizer chains, oldest sample at index LAST
  pixel_t [`SYNC_STAGES-1:0] data_sync;
  logic [`SYNC_STAGES-1:0] pclk_sync;
  logic [`SYNC_STAGES-1:0] hsync_sync;
  logic [`SYNC_STAGES-1:0] vsync_sync;
  // one more stage for edge detection
  logic pclk_d;
  logic hsync_d;
  logic vsync_d;
  logic pclk_rise;
  logic hsync_fall;
  logic vsync_rise;
  logic pix_emit;
  logic at_frame_end;
  hcount_t hcount;
  vcount_t vcount;

  // data rides the same depth as pclk so it lines up with the edge
  always_ff @(posedge clk_camera) begin
    data_sync <= {data_sync[LAST-1:0], camera_d_i};
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_sync <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
      pclk_d <= 1'b0;
      hsync_d <= 1'b0;
      vsync_d <= 1'b0;
    end else begin
      pclk_sync <= {pclk_sync[LAST-1:0], cam_pclk_i};
      hsync_sync <= {hsync_sync[LAST-1:0], cam_hsync_i};
      vsync_sync <= {vsync_sync[LAST-1:0], cam_vsync_i};
      pclk_d <= pclk_sync[LAST];
      hsync_d <= hsync_sync[LAST];
      vsync_d <= vsync_sync[LAST];
    end
  end

  assign pclk_rise = pclk_sync[LAST] & ~pclk_d;
  assign hsync_fall = ~hsync_sync[LAST] & hsync_d;
  assign vsync_rise = vsync_sync[LAST] & ~vsync_d;
  // sample only inside an active line
  assign pix_emit = pclk_rise & hsync_sync[LAST] & ~vsync_rise;
  assign at_frame_end = (hcount == hcount_t'(FRAME_W - 1)) &&
                        (vcount == vcount_t'(FRAME_H - 1));

  // vsync wins over hsync, hsync over pixels
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      hcount <= '0;
      vcount <= '0;
    end else if (vsync_rise) begin
      hcount <= '0;
      vcount <= '0;
    end else if (hsync_fall) begin
      hcount <= '0;
      vcount <= vcount + 1'b1;
    end else if (pix_emit) begin
      hcount <= hcount + 1'b1;
    end
  end

  // single-cycle pulse per pixel
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pix_o.tvalid <= 1'b0;
    end else begin
      pix_o.tvalid <= pix_emit;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (pix_emit) begin
      pix_o.tdata <= data_sync[LAST];
      pix_o.tlast <= at_frame_end;
    end
  end

endmodule

// File: common/axis_if.sv
`timescale 1ns/1ps

// valid/ready/last stream link
// transfer on a clk_camera edge with tvalid and tready both high
interface axis_if #(
  parameter type payload_t = logic
) ();

  logic     tvalid;
  logic     tready;
  payload_t tdata;
  // final transfer of a frame
  logic     tlast;

  // producing side
  modport source (
    output tvalid, tdata, tlast,
    input  tready
  );

  // consuming side
  modport sink (
    input  tvalid, tdata, tlast,
    output tready
  );

endinterface

// File: common/chunk_pkg.sv
`include "camera_consts.svh"

package chunk_pkg;

  import pixel_pkg::*;

  // lane 0 is the first pixel in time
  typedef pixel_t [`CHUNK_PIXELS-1:0] chunk_data_t;

  // 1..16 valid lanes, needs 5 bits
  typedef logic [$clog2(`CHUNK_PIXELS):0] lane_count_t;

  // data plus how many lanes hold real pixels
  // lanes at or above count are zero
  typedef struct packed {
    chunk_data_t data;
    lane_count_t count;
  } chunk_t;

  // full chunk width without the count field
  localparam int CHUNK_DATA_W = $bits(chunk_data_t);

endpackage

// File: common/pixel_pkg.sv
`include "camera_consts.svh"

package pixel_pkg;

  // one 8-bit luminance sample from the camera
  typedef logic [`PIXEL_W-1:0] pixel_t;

  // column within a line
  typedef logic [`HCOUNT_W-1:0] hcount_t;

  // row within a frame
  typedef logic [`VCOUNT_W-1:0] vcount_t;

  // largest column and row the counters can hold
  localparam int HCOUNT_MAX = (1 << `HCOUNT_W) - 1;
  localparam int VCOUNT_MAX = (1 << `VCOUNT_W) - 1;

  // Frame sizes above these limits would wrap the counters.
  // The capture block compares against FRAME_W-1 and FRAME_H-1,
  // so both must stay within range.

endpackage

// File: common/camera_consts.svh
`ifndef CAMERA_CONSTS_SVH
`define CAMERA_CONSTS_SVH

// luminance sample width
`define PIXEL_W 8

// one chunk as stored and queued
`define CHUNK_W 128
`define CHUNK_PIXELS 16

// default sensor frame, 640x360 mode
`define FRAME_W 640
`define FRAME_H 360

// pixel position counters
`define HCOUNT_W 11
`define VCOUNT_W 10

// chunk queue entries
`define FIFO_DEPTH 4

// flops per camera pin before use
`define SYNC_STAGES 2

`endif
